/* run_sim.sh */
#!/bin/sh
# Builds the store engine testbench with Verilator and runs it.
# The run counts as failed when the log holds the fail message.
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module vst_tb \
    -Mdir build/obj_dir \
    -o vst_sim

./build/obj_dir/vst_sim | tee build/sim.log

if grep -q "Done: errors found" build/sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
exit 0

/* sim/vst_checker.sv */
/*
 * Testbench checker: watches the store engine ports and compares requests,
 * unlock strobes and address ranges with a reference model of the store rules.
 */
`default_nettype none

`include "vst_settings.svh"

module vst_checker import vst_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    valid_i,
    input  vst_instr_t   instr_i,
    input  wire logic    ready_i,
    input  wire logic    req_en_i,
    input  vst_req_t     req_i,
    input  wire logic    grant_i,
    input  wire logic    unlock_en_i,
    input  vst_reg_num_t unlock_reg_i,
    input  wire logic    busy_i,
    input  vst_addr_t    start_addr_i,
    input  vst_addr_t    end_addr_i,
    output int           checks_o,
    output int           errors_o,
    output int           outstanding_o,   // Elements accepted but not yet granted
    output int           unlocks_left_o   // Registers still to be released
);
    timeunit 1ns;
    timeprecision 100ps;

    vst_req_t     exp_q[$];               // Expected requests in issue order
    vst_reg_num_t unlock_q[$];            // Expected unlock registers
    logic         seen_valid;             // First instruction offered
    logic         accepted_d;             // Accept in the previous cycle
    logic         req_held;               // Request waited for a grant
    vst_req_t     req_prev;
    vst_addr_t    exp_start;
    vst_addr_t    exp_end;
    int           gap_run;                // Busy cycles without a request

    // ==============================
    // Reference model
    // ==============================
    // Register-file contents, upper registers hold small index offsets
    function automatic vst_word_t reg_word(input int reg_num, input int lane);
        if (reg_num >= 24) begin
            return vst_word_t'(((reg_num * 5 + lane * 3) % 32) * 4);
        end
        return 32'hda00_0000 + vst_word_t'(reg_num << 12) + vst_word_t'(lane << 4)
               + vst_word_t'(reg_num ^ lane);
    endfunction

    // Element i of a store, register i div lanes, lane i mod lanes
    function automatic vst_req_t expected_req(input vst_instr_t ins, input int i);
        vst_req_t r;
        int       reg_off;
        int       lane;
        reg_off = i / `VST_LANES;
        lane    = i % `VST_LANES;
        r.data  = reg_word((int'(ins.data_reg) + reg_off) % `VST_VREGS, lane);
        case (ins.mem_op)
            STRIDED: r.addr = ins.base + vst_addr_t'(i) * ins.stride;
            INDEXED: r.addr = ins.base + reg_word((int'(ins.idx_reg) + reg_off) % `VST_VREGS, lane);
            default: r.addr = ins.base + vst_addr_t'(i * `VST_ELEM_BYTES);
        endcase
        return r;
    endfunction

    function automatic vst_addr_t expected_end(input vst_instr_t ins);
        vst_addr_t last;
        last = vst_addr_t'(ins.vl) - 1;    // Index of the final element
        case (ins.mem_op)
            STRIDED:      return ins.base + last * ins.stride;
            UNIT_STRIDED: return ins.base + last * vst_addr_t'(`VST_ELEM_BYTES);
            default:      return ins.base;  // Indexed end is unknown
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        checks_o++;
        if (exp_v !== act_v) begin
            errors_o++;
            $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic note_failure(input string msg);
        errors_o++;
        $display("At %0t ns: %s", $time, msg);
    endtask

    // ==============================
    // Port watch, sampled on the rising edge
    // ==============================
    always @(posedge clk) begin
        vst_req_t exp_r;
        if (!rst_n) begin
            exp_q.delete();
            unlock_q.delete();
            seen_valid     = 1'b0;
            accepted_d     = 1'b0;
            req_held       = 1'b0;
            req_prev       = '0;
            exp_start      = '0;
            exp_end        = '0;
            gap_run        = 0;
            checks_o       = 0;
            errors_o       = 0;
            outstanding_o  = 0;
            unlocks_left_o = 0;
        end else begin
            if (!seen_valid) begin          // Quiet until the first instruction
                compare_value("req_en_o", 32'(0), 32'(req_en_i));
                compare_value("busy_o", 32'(0), 32'(busy_i));
                compare_value("unlock_en_o", 32'(0), 32'(unlock_en_i));
                compare_value("ready_o", 32'(1), 32'(ready_i));
                compare_value("start_addr_o", '0, start_addr_i);   // Reset range
                compare_value("end_addr_o", '1, end_addr_i);
            end
            if (valid_i) seen_valid = 1'b1;
            if (accepted_d) begin           // Range and lane 0 right after accept
                compare_value("start_addr_o", exp_start, start_addr_i);
                compare_value("end_addr_o", exp_end, end_addr_i);
                compare_value("req_en_o", 32'(1), 32'(req_en_i));
            end
            if (req_held) begin             // Held request must not move
                compare_value("req_o.addr", req_prev.addr, req_i.addr);
                compare_value("req_o.data", req_prev.data, req_i.data);
            end
            if (req_en_i && grant_i) begin
                if (exp_q.size() == 0) begin
                    note_failure("a request was granted with no element outstanding");
                end else begin
                    exp_r = exp_q.pop_front();
                    compare_value("req_o.addr", exp_r.addr, req_i.addr);
                    compare_value("req_o.data", exp_r.data, req_i.data);
                    if (exp_q.size() == 0) begin    // Final grant of the store
                        compare_value("unlock_en_o", 32'(1), 32'(unlock_en_i));
                        compare_value("ready_o", 32'(1), 32'(ready_i));
                    end
                end
            end
            req_held = req_en_i && !grant_i;
            req_prev = req_i;
            if (unlock_en_i) begin
                if (unlock_q.size() == 0) begin
                    note_failure("unlock strobe with no register left to release");
                end else begin
                    compare_value("unlock_reg_o", 32'(unlock_q.pop_front()), 32'(unlock_reg_i));
                end
            end
            // Only the register boundary may leave one empty cycle
            gap_run = (busy_i && !req_en_i) ? gap_run + 1 : 0;
            if (gap_run == 2) note_failure("requests paused for more than one cycle in a store");
            // The boundary gap releases the finished register
            if (busy_i && !req_en_i) compare_value("unlock_en_o", 32'(1), 32'(unlock_en_i));
            accepted_d = valid_i && ready_i;
            if (accepted_d) begin
                for (int i = 0; i < int'(instr_i.vl); i++) begin
                    exp_q.push_back(expected_req(instr_i, i));
                end
                for (int k = 0; k < (int'(instr_i.vl) + `VST_LANES - 1) / `VST_LANES; k++) begin
                    unlock_q.push_back(vst_reg_num_t'((int'(instr_i.data_reg) + k) % `VST_VREGS));
                end
                exp_start = instr_i.base;
                exp_end   = expected_end(instr_i);
            end
            outstanding_o  = exp_q.size();
            unlocks_left_o = unlock_q.size();
        end
    end

endmodule

`default_nettype wire

/* sim/vst_tb.sv */
/*
 * Testbench top for the vector store engine: clock, reset, register-file model,
 * instruction and grant stimulus, watchdog. The checker module does the comparing.
 */
`default_nettype none

`include "vst_settings.svh"

module vst_tb import vst_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int N_INSTR      = 12;     // Directed plus random instructions
    localparam int N_RANDOM     = 6;      // Random stores after the directed ones
    localparam int MAX_VL       = 24;     // Longest store in the tests
    localparam int SLACK        = 40;     // Extra cycles per instruction

    logic         clk;
    logic         rst_n;
    logic         valid_i;
    vst_instr_t   instr_i;
    logic         ready_o;
    logic         grant_i;
    logic         req_en_o;
    vst_req_t     req_o;
    vst_reg_num_t rd_addr_data_o;
    vst_reg_num_t rd_addr_idx_o;
    vst_vreg_t    rd_data_data_i;
    vst_vreg_t    rd_data_idx_i;
    logic         unlock_en_o;
    vst_reg_num_t unlock_reg_o;
    logic         busy_o;
    vst_addr_t    start_addr_o;
    vst_addr_t    end_addr_o;

    int seed;
    int grant_pct;                        // Grant chance in percent
    int tb_errors;
    int checks;
    int errors;
    int outstanding;
    int unlocks_left;
    vst_instr_t rand_instrs[N_RANDOM];    // Random stores, drawn before the grants start

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==============================
    // Register-file model
    // ==============================
    function automatic vst_word_t reg_word(input int reg_num, input int lane);
        if (reg_num >= 24) begin      // Index registers
            return vst_word_t'(((reg_num * 5 + lane * 3) % 32) * 4);
        end
        return 32'hda00_0000 + vst_word_t'(reg_num << 12) + vst_word_t'(lane << 4)
               + vst_word_t'(reg_num ^ lane);
    endfunction

    always_comb begin
        for (int l = 0; l < `VST_LANES; l++) begin
            rd_data_data_i[l*`VST_DATA_W +: `VST_DATA_W] = reg_word(int'(rd_addr_data_o), l);
            rd_data_idx_i[l*`VST_DATA_W +: `VST_DATA_W]  = reg_word(int'(rd_addr_idx_o), l);
        end
    end

    // Memory side grants at random
    always @(posedge clk) begin
        if (!rst_n) grant_i <= 1'b0;
        else        grant_i <= ($unsigned($random(seed)) % 100) < grant_pct;
    end

    // ==============================
    // Stimulus helpers
    // ==============================
    function automatic vst_instr_t make_instr(input vst_mem_op_e op, input vst_addr_t base,
                                              input vst_addr_t stride, input int vl,
                                              input int dreg, input int ireg);
        vst_instr_t ins;
        ins.mem_op   = op;
        ins.base     = base;
        ins.stride   = stride;
        ins.vl       = vst_vl_t'(vl);
        ins.data_reg = vst_reg_num_t'(dreg);
        ins.idx_reg  = vst_reg_num_t'(ireg);
        return ins;
    endfunction

    function automatic vst_instr_t random_instr();
        vst_instr_t ins;
        ins.mem_op   = vst_mem_op_e'(2'($unsigned($random(seed)) % 3));
        ins.base     = ($unsigned($random(seed)) % 32'h1_0000) << 4;
        ins.stride   = (($unsigned($random(seed)) % 16) + 1) << 2;
        ins.vl       = vst_vl_t'(1 + $unsigned($random(seed)) % MAX_VL);
        ins.data_reg = vst_reg_num_t'($unsigned($random(seed)) % 20);   // Clear of index regs
        ins.idx_reg  = vst_reg_num_t'(24 + $unsigned($random(seed)) % 5);
        return ins;
    endfunction

    // Offer one instruction and return on the edge that takes it
    task automatic issue(input vst_instr_t ins);
        valid_i <= 1'b1;
        instr_i <= ins;
        @(posedge clk);
        while (!ready_o) @(posedge clk);
    endtask

    task automatic drain();
        valid_i <= 1'b0;
        @(posedge clk);
        while (busy_o) @(posedge clk);
    endtask

    task automatic finish_run();
        int total;
        if (outstanding != 0) begin
            $display("%0d store elements were never requested", outstanding);
            tb_errors++;
        end
        if (unlocks_left != 0) begin
            $display("%0d registers were never unlocked", unlocks_left);
            tb_errors++;
        end
        if (busy_o) begin
            $display("Engine still busy after the last store");
            tb_errors++;
        end
        total = errors + tb_errors;
        $display("Checks: %0d, errors: %0d", checks, total);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        seed      = 32'he874;
        grant_pct = 100;
        tb_errors = 0;
        rst_n     = 1'b0;
        valid_i   = 1'b0;
        instr_i   = '0;
        grant_i   = 1'b0;
        for (int n = 0; n < N_RANDOM; n++) begin
            rand_instrs[n] = random_instr();
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (5) @(posedge clk);                // Idle outputs checked here
        issue(make_instr(UNIT_STRIDED, 32'h0000_1000, 0, 5, 3, 0));
        drain();
        issue(make_instr(STRIDED, 32'h0002_0000, 12, 20, 8, 0));    // Three registers
        drain();
        grant_pct = 60;
        issue(make_instr(INDEXED, 32'h0004_0000, 0, 12, 2, 24));
        drain();
        // Back-to-back, each taken on the final grant of the one before
        issue(make_instr(UNIT_STRIDED, 32'h0006_0100, 0, 9, 12, 0));
        issue(make_instr(STRIDED, 32'h0008_0000, 32'hffff_fff8, 24, 16, 0));
        issue(make_instr(INDEXED, 32'h000a_0000, 0, 7, 5, 26));
        for (int n = 0; n < N_RANDOM; n++) begin
            issue(rand_instrs[n]);
        end
        drain();
        repeat (4) @(posedge clk);
        finish_run();
    end

    // Watchdog
    initial begin
        #((RESET_CYCLES + N_INSTR * (MAX_VL * 4 + SLACK)) * CLK_PERIOD);
        $display("Watchdog: the stores did not complete in the expected time");
        $display("Done: errors found");
        $finish;
    end

    vst_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_i        (valid_i),
        .instr_i        (instr_i),
        .ready_o        (ready_o),
        .rd_addr_data_o (rd_addr_data_o),
        .rd_data_data_i (rd_data_data_i),
        .rd_addr_idx_o  (rd_addr_idx_o),
        .rd_data_idx_i  (rd_data_idx_i),
        .grant_i        (grant_i),
        .req_en_o       (req_en_o),
        .req_o          (req_o),
        .unlock_en_o    (unlock_en_o),
        .unlock_reg_o   (unlock_reg_o),
        .busy_o         (busy_o),
        .start_addr_o   (start_addr_o),
        .end_addr_o     (end_addr_o)
    );

    vst_checker u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_i        (valid_i),
        .instr_i        (instr_i),
        .ready_i        (ready_o),
        .req_en_i       (req_en_o),
        .req_i          (req_o),
        .grant_i        (grant_i),
        .unlock_en_i    (unlock_en_o),
        .unlock_reg_i   (unlock_reg_o),
        .busy_i         (busy_o),
        .start_addr_i   (start_addr_o),
        .end_addr_i     (end_addr_o),
        .checks_o       (checks),
        .errors_o       (errors),
        .outstanding_o  (outstanding),
        .unlocks_left_o (unlocks_left)
    );

endmodule

`default_nettype wire

/* sources.f */
+incdir+src
src/vst_pkg.sv
src/vst_ctrl.sv
src/vst_req_gen.sv
src/vst_range_track.sv
src/vst_top.sv
sim/vst_checker.sv
sim/vst_tb.sv

/* src/vst_ctrl.sv */
/*
 * Control side of the store engine: handshakes, lane walk and register expansion.
 * Drives the step bundle that the address and range datapaths follow.
 */
`default_nettype none

`include "vst_settings.svh"

module vst_ctrl import vst_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst_n,
    // Instruction handshake
    input  wire logic         valid_i,
    input  vst_instr_t        instr_i,
    output logic              ready_o,
    // Memory handshake
    input  wire logic         grant_i,
    output logic              req_en_o,
    // Datapath control
    output vst_step_t         step_o,
    input  vst_mem_op_e       mem_op_i,      // Op of the running instruction
    // Register file read ports
    output vst_reg_num_t      rd_addr_data_o,
    output vst_reg_num_t      rd_addr_idx_o,
    // Unlock strobe and status
    output logic              unlock_en_o,
    output vst_reg_num_t      unlock_reg_o,
    output logic              busy_o
);

    // ==============================
    // State
    // ==============================
    logic                  active_r;    // An instruction is in flight
    vst_lane_t             lane_r;      // Lane pointer
    logic [`VST_LANES-1:0] pending_r;   // Lanes still to be written
    vst_reg_num_t          loop_r;      // Expansion count, registers done
    vst_reg_num_t          data_reg_r;
    vst_reg_num_t          idx_reg_r;
    vst_vl_t               vl_r;

    logic                  accept;
    logic                  grant_fire;
    logic [`VST_LANES-1:0] lane_oh;
    logic [`VST_LANES-1:0] pend_next;
    logic                  reg_done;    // Last pending lane granted
    logic                  last_loop;   // Current register ends the vector
    logic                  boundary;    // Gap cycle between two registers
    logic                  finish;
    vst_vl_t               served;      // Elements covered up to this register
    vst_vl_t               remaining;

    // Ones for the lowest cnt lanes, saturating at a full register
    function automatic logic [`VST_LANES-1:0] lane_mask(input vst_vl_t cnt);
        logic [`VST_LANES-1:0] m;
        m = '0;
        for (int i = 0; i < `VST_LANES; i++) begin
            m[i] = (cnt > i);
        end
        return m;
    endfunction

    // ==============================
    // Flow decode
    // ==============================
    assign accept     = valid_i & ready_o;
    assign req_en_o   = |pending_r;                 // Any lane left in this register
    assign grant_fire = req_en_o & grant_i;

    assign lane_oh    = `VST_LANES'(1) << lane_r;
    assign pend_next  = pending_r & ~lane_oh;
    assign reg_done   = grant_fire & ~|pend_next;

    // Served count after the current register, 32 registers fit in vl width
    assign served     = (vst_vl_t'(loop_r) + vst_vl_t'(1)) << `VST_LANE_W;
    assign remaining  = vl_r - served;
    assign last_loop  = (served >= vl_r);

    assign finish     = reg_done & last_loop;       // Final grant of the instruction
    assign boundary   = active_r & ~req_en_o & ~last_loop;

    // Idle, or taking the next one on the final grant
    assign ready_o    = (~req_en_o & ~boundary) | finish;
    assign busy_o     = active_r;

    assign unlock_en_o  = boundary | finish;
    assign unlock_reg_o = data_reg_r;               // Register just finished

    assign rd_addr_data_o = data_reg_r;
    // Index port parked unless the op reads it
    assign rd_addr_idx_o  = (mem_op_i == INDEXED) ? idx_reg_r : '0;

    assign step_o.start   = accept;
    assign step_o.advance = grant_fire;
    assign step_o.lane    = lane_r;

    // ==============================
    // Sequencing
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_r   <= 1'b0;
            lane_r     <= '0;
            pending_r  <= '0;
            loop_r     <= '0;
            data_reg_r <= '0;
            idx_reg_r  <= '0;
            vl_r       <= '0;
        end else if (accept) begin
            // New instruction, also valid on the final grant of the last one
            active_r   <= 1'b1;
            lane_r     <= '0;
            pending_r  <= lane_mask(instr_i.vl);
            loop_r     <= '0;
            data_reg_r <= instr_i.data_reg;
            idx_reg_r  <= instr_i.idx_reg;
            vl_r       <= instr_i.vl;
        end else if (finish) begin
            active_r   <= 1'b0;
            lane_r     <= '0;
            pending_r  <= pend_next;                // All clear
        end else if (boundary) begin
            lane_r     <= '0;
            pending_r  <= lane_mask(remaining);     // Refill for the next register
            loop_r     <= loop_r + 1'b1;
            data_reg_r <= data_reg_r + 1'b1;
            idx_reg_r  <= idx_reg_r + 1'b1;
        end else if (grant_fire) begin
            lane_r     <= lane_r + 1'b1;            // Wraps after the top lane
            pending_r  <= pend_next;
        end
    end

    // ==============================
    // Checks
    // ==============================
    // Pointer stays on a pending lane while requesting
    a_lane_pending: assert property (@(posedge clk) disable iff (!rst_n)
        req_en_o |-> pending_r[lane_r])
        else $error("vst_ctrl: request on a lane that is not pending");

    a_ready_or_busy: assert property (@(posedge clk) disable iff (!rst_n)
        ready_o || busy_o)
        else $error("vst_ctrl: neither ready nor busy");

endmodule

`default_nettype wire

/* src/vst_pkg.sv */
/*
 * Types shared by the store engine modules and the testbench.
 * Import with a wildcard in the module header.
 */
`default_nettype none

`include "vst_settings.svh"

package vst_pkg;

    // Scalar helpers
    typedef logic [`VST_ADDR_W-1:0]           vst_addr_t;    // Byte address
    typedef logic [`VST_DATA_W-1:0]           vst_word_t;    // One element
    typedef logic [`VST_LANES*`VST_DATA_W-1:0] vst_vreg_t;   // Lane-packed register
    typedef logic [`VST_VREG_W-1:0]           vst_reg_num_t; // Register number
    typedef logic [`VST_LANE_W-1:0]           vst_lane_t;    // Lane index
    typedef logic [`VST_VL_W-1:0]             vst_vl_t;      // Vector length

    // Memory-op field of a store
    typedef enum logic [1:0] {
        UNIT_STRIDED = 2'd0,
        STRIDED      = 2'd1,
        INDEXED      = 2'd2
    } vst_mem_op_e;

    // ==============================
    // Bundles
    // ==============================
    typedef struct packed {
        vst_mem_op_e  mem_op;   // Addressing mode
        vst_addr_t    base;     // First address
        vst_addr_t    stride;   // Byte stride, strided mode only
        vst_vl_t      vl;       // Element count
        vst_reg_num_t data_reg; // First source data register
        vst_reg_num_t idx_reg;  // First index register
    } vst_instr_t;

    // Control to datapath, one step of the expansion
    typedef struct packed {
        logic      start;   // Instruction accepted this cycle
        logic      advance; // Current request granted
        vst_lane_t lane;    // Lane being served
    } vst_step_t;

    typedef struct packed {
        vst_addr_t addr;
        vst_word_t data;
    } vst_req_t;

endpackage

`default_nettype wire

/* src/vst_range_track.sv */
/*
 * Records the address range of the running store for hazard checks.
 * Indexed stores report only their base, the end is unknown.
 */
`default_nettype none

`include "vst_settings.svh"

module vst_range_track import vst_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  start_i,       // Instruction accepted
    input  vst_instr_t instr_i,
    output vst_addr_t  start_addr_o,
    output vst_addr_t  end_addr_o
);

    vst_addr_t vl_m1;        // Last element index
    vst_addr_t end_nxt;

    assign vl_m1 = vst_addr_t'(instr_i.vl) - vst_addr_t'(1);

    // End of range per memory op
    always_comb begin
        case (instr_i.mem_op)
            STRIDED:      end_nxt = instr_i.base + vl_m1 * instr_i.stride;
            UNIT_STRIDED: end_nxt = instr_i.base + vl_m1 * vst_addr_t'(`VST_ELEM_BYTES);
            default:      end_nxt = instr_i.base;
        endcase
    end

    // Reset gives an empty-safe full range
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_addr_o <= '0;
            end_addr_o   <= '1;
        end else if (start_i) begin
            start_addr_o <= instr_i.base;
            end_addr_o   <= end_nxt;
        end
    end

    // A zero-length store would never finish in the control loop
    a_vl_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> (instr_i.vl != '0))
        else $error("vst_range_track: store accepted with vl of zero");

endmodule

`default_nettype wire

/* src/vst_req_gen.sv */
/*
 * Request datapath: forms the address and data of each store element.
 * Follows the step bundle from the control module, no extra latency.
 */
`default_nettype none

`include "vst_settings.svh"

module vst_req_gen import vst_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  vst_instr_t  instr_i,
    input  vst_step_t   step_i,
    input  vst_vreg_t   rd_data_data_i,   // Data register, lane-packed
    input  vst_vreg_t   rd_data_idx_i,    // Index register, lane-packed
    output vst_mem_op_e mem_op_o,
    output vst_req_t    req_o
);

    // ==============================
    // Captured instruction fields
    // ==============================
    vst_mem_op_e mem_op_r;
    vst_addr_t   base_r;
    vst_addr_t   stride_r;
    vst_addr_t   addr_r;       // Running address, strided modes

    vst_word_t   data_word;
    vst_word_t   idx_word;
    vst_addr_t   addr_inc;

    // Current lane words from both read ports
    assign data_word = rd_data_data_i[step_i.lane*`VST_DATA_W +: `VST_DATA_W];
    assign idx_word  = rd_data_idx_i[step_i.lane*`VST_DATA_W +: `VST_DATA_W];

    // Step applied on each grant
    always_comb begin
        case (mem_op_r)
            STRIDED:      addr_inc = stride_r;
            UNIT_STRIDED: addr_inc = vst_addr_t'(`VST_ELEM_BYTES);
            default:      addr_inc = '0;            // Indexed uses the lane offset instead
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_op_r <= UNIT_STRIDED;
            base_r   <= '0;
            stride_r <= '0;
            addr_r   <= '0;
        end else if (step_i.start) begin
            mem_op_r <= instr_i.mem_op;
            base_r   <= instr_i.base;
            stride_r <= instr_i.stride;
            addr_r   <= instr_i.base;               // First element at base
        end else if (step_i.advance) begin
            addr_r   <= addr_r + addr_inc;
        end
    end

    // ==============================
    // Request forming
    // ==============================
    always_comb begin
        if (mem_op_r == INDEXED) begin
            req_o.addr = base_r + vst_addr_t'(idx_word);  // Base plus lane offset
        end else begin
            req_o.addr = addr_r;
        end
        req_o.data = data_word;
    end

    assign mem_op_o = mem_op_r;

    // Op field must decode once an instruction is taken
    a_mem_op_known: assert property (@(posedge clk) disable iff (!rst_n)
        step_i.start |=> (mem_op_r inside {UNIT_STRIDED, STRIDED, INDEXED}))
        else $error("vst_req_gen: unused memory-op code captured");

endmodule

`default_nettype wire

/* src/vst_settings.svh */
/*
 * Build-wide sizes for the vector store engine.
 * Include this wherever lane, register or address widths are needed.
 */
`ifndef VST_SETTINGS_SVH
`define VST_SETTINGS_SVH

// ==============================
// Base sizes
// ==============================
`define VST_LANES      8                    // Elements per vector register
`define VST_VREGS      32                   // Vector registers in the file
`define VST_DATA_W     32                   // Element width in bits
`define VST_ADDR_W     32                   // Byte address width

// ==============================
// Derived sizes
// ==============================
`define VST_ELEM_BYTES (`VST_DATA_W/8)      // Unit stride in bytes
`define VST_LANE_W     $clog2(`VST_LANES)   // Lane pointer width
`define VST_VREG_W     $clog2(`VST_VREGS)   // Register number width
// Vector length spans all registers, plus one bit for the full count
`define VST_VL_W       ($clog2(`VST_VREGS*`VST_LANES)+1)

`endif

/* src/vst_top.sv */
/*
 * Vector store engine top, joins control, request and range blocks.
 */
`default_nettype none

`include "vst_settings.svh"

module vst_top import vst_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    // Instruction input
    input  wire logic   valid_i,
    input  vst_instr_t  instr_i,
    output logic        ready_o,
    // Register file
    output vst_reg_num_t rd_addr_data_o,
    input  vst_vreg_t   rd_data_data_i,
    output vst_reg_num_t rd_addr_idx_o,
    input  vst_vreg_t   rd_data_idx_i,
    // Memory request
    input  wire logic   grant_i,
    output logic        req_en_o,
    output vst_req_t    req_o,
    // Unlock and sync
    output logic        unlock_en_o,
    output vst_reg_num_t unlock_reg_o,
    output logic        busy_o,
    output vst_addr_t   start_addr_o,
    output vst_addr_t   end_addr_o
);

    vst_step_t   step;       // Shared step of the expansion
    vst_mem_op_e mem_op;     // Running op, back to control

    vst_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_i        (valid_i),
        .instr_i        (instr_i),
        .ready_o        (ready_o),
        .grant_i        (grant_i),
        .req_en_o       (req_en_o),
        .step_o         (step),
        .mem_op_i       (mem_op),
        .rd_addr_data_o (rd_addr_data_o),
        .rd_addr_idx_o  (rd_addr_idx_o),
        .unlock_en_o    (unlock_en_o),
        .unlock_reg_o   (unlock_reg_o),
        .busy_o         (busy_o)
    );

    vst_req_gen u_req_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_i        (instr_i),
        .step_i         (step),
        .rd_data_data_i (rd_data_data_i),
        .rd_data_idx_i  (rd_data_idx_i),
        .mem_op_o       (mem_op),
        .req_o          (req_o)
    );

    vst_range_track u_range (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (step.start),
        .instr_i        (instr_i),
        .start_addr_o   (start_addr_o),
        .end_addr_o     (end_addr_o)
    );

endmodule

`default_nettype wire
